//--- files.f
+incdir+testbench
hw/rtg_pkg.sv
hw/rtg_pixel_timing.sv
hw/rtg_vblank_extend.sv
hw/rtg_clut.sv
hw/rtg_pixel_decode.sv
hw/video_out_mix.sv
hw/rtg_video_top.sv
testbench/tb_rtg_video.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_rtg_video
FILELIST = files.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

//--- testbench/tb_rtg_model.svh
`ifndef TB_RTG_MODEL_SVH
`define TB_RTG_MODEL_SVH

////////////////////////////////////////////////////////////////////////
// Reference model of the RTG display path
////////////////////////////////////////////////////////////////////////

// Field widened to 8 bits, top bits copied into the bottom
function automatic logic [7:0] widen5(input logic [4:0] f);
	return (8'(f) << 3) | 8'(f >> 2);
endfunction

function automatic logic [7:0] widen6(input logic [5:0] f);
	return (8'(f) << 2) | 8'(f >> 4);
endfunction

// Expected {r, g, b} of one high colour word
function automatic logic [23:0] hc_colour(input logic [15:0] w, input logic is16);
	if (is16)
		return {widen5(w[15:11]), widen6(w[10:5]), widen5(w[4:0])}; // 565
	else
		return {widen5(w[14:10]), widen5(w[9:5]), widen5(w[4:0])};  // 555, bit 15 dropped
endfunction

// OSD overlay of one channel
function automatic logic [7:0] osd_mix(input logic win, input logic pix, input logic blue,
	input logic [7:0] c);
	logic [1:0] code;
	code = pix ? 2'b11 : (blue ? 2'b10 : 2'b00);
	return win ? {code, c[7:2]} : c;
endfunction

// Output sync with polarity, inverted only in native modes
function automatic logic sync_out(input logic s, input logic pol, input logic inv,
	input logic ena);
	return s ^ pol ^ (inv & ~ena);
endfunction

// Galois LFSR, one bit per step
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
	return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

`endif

//--- testbench/tb_rtg_video.sv
`timescale 1ns/1ps

module tb_rtg_video;
	import rtg_pkg::*;

	`include "tb_rtg_model.svh"

	localparam int VB_W    = 7;
	localparam int ACTIVE  = 48;
	localparam int BLANK   = 16;
	localparam int LINE    = ACTIVE + BLANK;
	localparam int NAT_CYC = 64;
	// Sum of all test lengths doubled for margin
	localparam int LIMIT   = 2 * (27 * LINE + CLUT_DEPTH + 3 * NAT_CYC + 200);
	localparam logic [23:0] NAT = 24'h5AA53C;

	logic CLK_114 = 1'b0;
	logic rst;
	logic rtg_ena, rtg_clut_mode, rtg_16bit, scandbl_off, invert_sync, hsync_pol, vsync_pol;
	logic [PIXW_W-1:0] pixel_width;
	logic [VB_W-1:0] vb_end;
	logic clut_we;
	logic [7:0] clut_wr_idx, clut_wr_r, clut_wr_g, clut_wr_b;
	logic hs, vs, cs, hblank, vblank, osd_window, osd_pixel;
	logic [7:0] nat_r, nat_g, nat_b;
	pixel_word_t rtg_dat;
	logic pixel_req, vga_pixel, vga_hs, vga_vs, vga_cs;
	logic [7:0] vga_r, vga_g, vga_b;

	logic [15:0] lfsr = 16'd96;
	logic [23:0] pal [CLUT_DEPTH];
	logic        pend_v [4];  // Expected colour pipeline with slot 0 compared
	logic [23:0] pend_c [4];
	logic        pend_sv [4];
	logic [2:0]  pend_s [4];
	logic chk_req = 0, chk_hc = 0, chk_clut = 0, chk_vb = 0, chk_nat = 0;
	logic req_prev = 0, hs_prev = 0, have_pix = 0;
	int line_pos = 0, req_cnt = 0, edges = 0, reqs_after = 0, gap = 0, period = 8;
	int pix_cnt = 0;
	int n_checks = 0, n_err = 0, err_mark = 0, cycles = 0;

	rtg_video_top #(.VBEND_W(VB_W)) u_dut (.*);

	always #4 CLK_114 = ~CLK_114; // 8 ns

	always @(posedge CLK_114) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("Timeout: the run went past %0d cycles", LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	function automatic logic [23:0] rand_bits(input int n);
		logic [23:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[22:0], lfsr[0]};
		end
		return r;
	endfunction

	// Pixel source puts out a new word the clock after each fetch strobe
	always @(posedge CLK_114) begin
		if (req_prev) begin
			#1 rtg_dat = 16'(rand_bits(16));
		end
	end

	task automatic step();
		@(posedge CLK_114);
		#1;
	endtask

	task automatic check_val(input string name, input logic [23:0] got, input logic [23:0] exp);
		n_checks++;
		if (got !== exp) begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			n_err++;
		end
	endtask

	task automatic put(input int d, input logic [23:0] c);
		pend_v[d] = 1'b1;
		pend_c[d] = c;
	endtask

	////////////////////////////////////////////////////////////////////
	// Comparison process sampled mid cycle
	////////////////////////////////////////////////////////////////////

	always @(negedge CLK_114) begin
		for (int i = 0; i < 3; i++) begin
			pend_v[i]  = pend_v[i+1];
			pend_c[i]  = pend_c[i+1];
			pend_sv[i] = pend_sv[i+1];
			pend_s[i]  = pend_s[i+1];
		end
		pend_v[3]  = 1'b0;
		pend_sv[3] = 1'b0;
		if (pend_v[0]) begin
			check_val("vga_r", vga_r, pend_c[0][23:16]);
			check_val("vga_g", vga_g, pend_c[0][15:8]);
			check_val("vga_b", vga_b, pend_c[0][7:0]);
		end
		if (pend_sv[0]) begin
			check_val("vga_hs", vga_hs, pend_s[0][2]);
			check_val("vga_vs", vga_vs, pend_s[0][1]);
			check_val("vga_cs", vga_cs, pend_s[0][0]);
		end
		if (chk_req) begin
			if (hblank) begin
				line_pos = 0;
			end else begin
				check_val("pixel_req", pixel_req,
					rtg_ena && ((line_pos + 1) % (pixel_width + 1) == 0));
				if (pixel_req)
					req_cnt++;
				line_pos++;
			end
		end
		if (chk_hc) begin
			check_val("vga_pixel", vga_pixel, req_prev); // One clock after the fetch
			if (vga_pixel)
				put(2, hc_colour(rtg_dat, rtg_16bit)); // Colour two clocks on
		end
		if (chk_clut && vga_pixel) begin // Strobe after a fetch is the high byte
			pix_cnt++;
			put(3, hblank ? NAT : pal[req_prev ? rtg_dat[15:8] : rtg_dat[7:0]]);
		end
		if (chk_vb) begin
			if (hs && !hs_prev)
				edges++;
			if (edges < vb_end) begin
				if (pixel_req) begin
					$display("pixel_req raised while vertical blank is still extended");
					n_err++;
				end
				check_val("vga_rgb", {vga_r, vga_g, vga_b}, NAT);
			end else if (pixel_req) begin
				reqs_after++;
			end
		end
		if (chk_nat) begin
			// Native colour whenever RTG is off or blanked
			put(1, {osd_mix(osd_window, osd_pixel, 1'b0, nat_r),
				osd_mix(osd_window, osd_pixel, 1'b0, nat_g),
				osd_mix(osd_window, osd_pixel, 1'b1, nat_b)});
			pend_sv[1] = 1'b1;
			pend_s[1]  = {sync_out(hs, hsync_pol, invert_sync, rtg_ena),
				sync_out(vs, vsync_pol, invert_sync, rtg_ena), cs};
			gap++;
			if (period == 0) begin
				check_val("vga_pixel", vga_pixel, 1'b0); // No strobe while RTG is blanked
			end else if (vga_pixel) begin
				if (have_pix)
					check_val("vga_pixel gap", gap, period);
				have_pix = 1'b1;
				gap = 0;
			end
		end
		req_prev = pixel_req;
		hs_prev  = hs;
	end

	////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////

	task automatic run_line(input logic with_hs);
		for (int i = 0; i < BLANK; i++) begin
			step();
			hblank = 1'b1;
			hs = with_hs && i >= 2 && i < 6;
		end
		for (int i = 0; i < ACTIVE; i++) begin
			step();
			hblank = 1'b0;
		end
		step();
		hblank = 1'b1;
	endtask

	task automatic report(input string name);
		$display("test %s: %0d errors", name, n_err - err_mark);
		err_mark = n_err;
	endtask

	initial begin
		for (int i = 0; i < 4; i++) begin
			pend_v[i]  = 1'b0;
			pend_sv[i] = 1'b0;
		end
		rst = 1'b1;
		{rtg_ena, rtg_clut_mode, rtg_16bit, scandbl_off, invert_sync, hsync_pol, vsync_pol} = '0;
		pixel_width = '0;
		vb_end = '0;
		{clut_we, clut_wr_idx, clut_wr_r, clut_wr_g, clut_wr_b} = '0;
		{hs, vs, cs, vblank, osd_window, osd_pixel} = '0;
		hblank = 1'b1;
		{nat_r, nat_g, nat_b} = NAT;
		rtg_dat = '0;
		repeat (4) @(posedge CLK_114);
		#1 rst = 1'b0;
		repeat (8) step();

		// Fetch cadence
		rtg_ena = 1'b1;
		chk_req = 1'b1;
		for (int k = 0; k < 3; k++) begin
			pixel_width = (k == 0) ? 4'd0 : (k == 1) ? 4'd3 : 4'd7;
			for (int l = 0; l < 2; l++) begin
				req_cnt = 0;
				run_line(1'b0);
				check_val("pixel_req count", req_cnt, ACTIVE / (pixel_width + 1));
			end
		end
		chk_req = 1'b0;
		report("fetch cadence");

		// High colour in 565 then 555
		pixel_width = 4'd3;
		rtg_16bit = 1'b1;
		chk_hc = 1'b1;
		for (int l = 0; l < 8; l++) begin
			if (l == 4) begin
				repeat (4) step(); // Drain before the mode change
				rtg_16bit = 1'b0;
			end
			run_line(1'b0);
		end
		repeat (4) step();
		chk_hc = 1'b0;
		report("high colour decode");

		// Palette load then two indices per word
		for (int i = 0; i < CLUT_DEPTH; i++) begin
			step();
			clut_we = 1'b1;
			clut_wr_idx = 8'(i);
			{clut_wr_r, clut_wr_g, clut_wr_b} = rand_bits(24);
			pal[i] = {clut_wr_r, clut_wr_g, clut_wr_b};
		end
		step();
		clut_we = 1'b0;
		rtg_clut_mode = 1'b1;
		repeat (4) step();
		pix_cnt = 0;
		chk_clut = 1'b1;
		for (int l = 0; l < 4; l++)
			run_line(1'b0);
		repeat (4) step();
		chk_clut = 1'b0;
		rtg_clut_mode = 1'b0;
		// Two strobes per fetch period, one per palette byte
		check_val("vga_pixel count", pix_cnt, 4 * 2 * ACTIVE / (pixel_width + 1));
		report("palette mode");

		// Vertical blank extension
		vb_end = 7'd3;
		vblank = 1'b1;
		run_line(1'b1);
		run_line(1'b1);
		step();
		vblank = 1'b0;
		edges = 0;
		reqs_after = 0;
		chk_vb = 1'b1;
		for (int l = 0; l < 5; l++)
			run_line(1'b1);
		chk_vb = 1'b0;
		if (reqs_after == 0) begin
			$display("No pixel_req after the vertical blank extension ended");
			n_err++;
		end
		report("vblank extension");

		// Native pass-through with OSD and syncs
		for (int m = 0; m < 3; m++) begin
			step();
			rtg_ena = (m == 2);     // Last pass has RTG on but blanked
			scandbl_off = (m == 1);
			period = (m == 2) ? 0 : (m == 1) ? 4 : 8;
			have_pix = 1'b0;
			chk_nat = 1'b1;
			for (int i = 0; i < NAT_CYC; i++) begin
				step();
				{nat_r, nat_g, nat_b} = rand_bits(24);
				{osd_window, osd_pixel, hs, vs, cs} = 5'(rand_bits(5));
				{hsync_pol, vsync_pol, invert_sync} = 3'(rand_bits(3));
			end
			step();
			chk_nat = 1'b0;
		end
		repeat (2) step();
		report("native pass-through");

		$display("checks %0d, errors %0d", n_checks, n_err);
		if (n_err == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- hw/rtg_video_top.sv
`timescale 1ns/1ps

module rtg_video_top #(
	parameter int VBEND_W = 7
) (
	input  logic                          CLK_114,
	input  logic                          rst,
	// Configuration
	input  logic                          rtg_ena,
	input  logic                          rtg_clut_mode,
	input  logic                          rtg_16bit,
	input  logic [rtg_pkg::PIXW_W-1:0]     pixel_width,
	input  logic [VBEND_W-1:0]            vb_end,
	input  logic                          scandbl_off,
	input  logic                          invert_sync,
	input  logic                          hsync_pol,
	input  logic                          vsync_pol,
	// Palette write
	input  logic                          clut_we,
	input  logic [rtg_pkg::CLUT_IDX_W-1:0] clut_wr_idx,
	input  logic [rtg_pkg::COLOR_W-1:0]    clut_wr_r,
	input  logic [rtg_pkg::COLOR_W-1:0]    clut_wr_g,
	input  logic [rtg_pkg::COLOR_W-1:0]    clut_wr_b,
	// Native chipset video
	input  logic                          hs,
	input  logic                          vs,
	input  logic                          cs,
	input  logic                          hblank,
	input  logic                          vblank,
	input  logic [rtg_pkg::COLOR_W-1:0]    nat_r,
	input  logic [rtg_pkg::COLOR_W-1:0]    nat_g,
	input  logic [rtg_pkg::COLOR_W-1:0]    nat_b,
	input  logic                          osd_window,
	input  logic                          osd_pixel,
	// Pixel stream
	input  rtg_pkg::pixel_word_t          rtg_dat,     // Valid the clock after pixel_req
	output logic                          pixel_req,
	// Video out
	output logic                          vga_pixel,
	output logic [rtg_pkg::COLOR_W-1:0]    vga_r,
	output logic [rtg_pkg::COLOR_W-1:0]    vga_g,
	output logic [rtg_pkg::COLOR_W-1:0]    vga_b,
	output logic                          vga_hs,
	output logic                          vga_vs,
	output logic                          vga_cs
);
	import rtg_pkg::*;

	logic                  rtg_vblank;
	logic                  byte_sel;
	logic                  blank_d2;
	logic [CLUT_IDX_W-1:0] clut_rd_idx;
	logic [COLOR_W-1:0]    hc_r, hc_g, hc_b;
	logic [COLOR_W-1:0]    clut_r, clut_g, clut_b;

	////////////////////////////////////////////////////////////////////
	// Timing
	////////////////////////////////////////////////////////////////////

	rtg_vblank_extend #(.VBEND_W(VBEND_W)) u_vblank_extend (
		.CLK_114    (CLK_114),
		.rst        (rst),
		.vblank     (vblank),
		.hs         (hs),
		.vb_end     (vb_end),
		.rtg_vblank (rtg_vblank)
	);

	rtg_pixel_timing u_pixel_timing (
		.CLK_114       (CLK_114),
		.rst           (rst),
		.rtg_ena       (rtg_ena),
		.rtg_clut_mode (rtg_clut_mode),
		.scandbl_off   (scandbl_off),
		.pixel_width   (pixel_width),
		.rtg_vblank    (rtg_vblank),
		.hblank        (hblank),
		.pixel_req     (pixel_req),
		.byte_sel      (byte_sel),
		.blank_d2      (blank_d2),
		.vga_pixel     (vga_pixel)
	);

	////////////////////////////////////////////////////////////////////
	// Pixel data
	////////////////////////////////////////////////////////////////////

	rtg_pixel_decode u_pixel_decode (
		.rtg_dat     (rtg_dat),
		.byte_sel    (byte_sel),
		.rtg_16bit   (rtg_16bit),
		.hc_r        (hc_r),
		.hc_g        (hc_g),
		.hc_b        (hc_b),
		.clut_rd_idx (clut_rd_idx)
	);

	rtg_clut u_clut (
		.CLK_114     (CLK_114),
		.clut_we     (clut_we),
		.clut_wr_idx (clut_wr_idx),
		.clut_wr_r   (clut_wr_r),
		.clut_wr_g   (clut_wr_g),
		.clut_wr_b   (clut_wr_b),
		.rd_idx      (clut_rd_idx),
		.rd_r        (clut_r),
		.rd_g        (clut_g),
		.rd_b        (clut_b)
	);

	video_out_mix u_out_mix (
		.CLK_114       (CLK_114),
		.rst           (rst),
		.rtg_ena       (rtg_ena),
		.rtg_clut_mode (rtg_clut_mode),
		.blank_d2      (blank_d2),
		.hc_r          (hc_r),
		.hc_g          (hc_g),
		.hc_b          (hc_b),
		.clut_r        (clut_r),
		.clut_g        (clut_g),
		.clut_b        (clut_b),
		.nat_r         (nat_r),
		.nat_g         (nat_g),
		.nat_b         (nat_b),
		.hs            (hs),
		.vs            (vs),
		.cs            (cs),
		.hsync_pol     (hsync_pol),
		.vsync_pol     (vsync_pol),
		.invert_sync   (invert_sync),
		.osd_window    (osd_window),
		.osd_pixel     (osd_pixel),
		.vga_r         (vga_r),
		.vga_g         (vga_g),
		.vga_b         (vga_b),
		.vga_hs        (vga_hs),
		.vga_vs        (vga_vs),
		.vga_cs        (vga_cs)
	);

endmodule

//--- hw/video_out_mix.sv
`timescale 1ns/1ps

module video_out_mix (
	input  logic                       CLK_114,
	input  logic                       rst,
	input  logic                       rtg_ena,
	input  logic                       rtg_clut_mode,
	input  logic                       blank_d2,
	input  logic [rtg_pkg::COLOR_W-1:0] hc_r,        // High colour, straight from decode
	input  logic [rtg_pkg::COLOR_W-1:0] hc_g,
	input  logic [rtg_pkg::COLOR_W-1:0] hc_b,
	input  logic [rtg_pkg::COLOR_W-1:0] clut_r,      // Palette, already registered
	input  logic [rtg_pkg::COLOR_W-1:0] clut_g,
	input  logic [rtg_pkg::COLOR_W-1:0] clut_b,
	input  logic [rtg_pkg::COLOR_W-1:0] nat_r,       // Native chipset colour
	input  logic [rtg_pkg::COLOR_W-1:0] nat_g,
	input  logic [rtg_pkg::COLOR_W-1:0] nat_b,
	input  logic                       hs,
	input  logic                       vs,
	input  logic                       cs,
	input  logic                       hsync_pol,
	input  logic                       vsync_pol,
	input  logic                       invert_sync,
	input  logic                       osd_window,
	input  logic                       osd_pixel,
	output logic [rtg_pkg::COLOR_W-1:0] vga_r,
	output logic [rtg_pkg::COLOR_W-1:0] vga_g,
	output logic [rtg_pkg::COLOR_W-1:0] vga_b,
	output logic                       vga_hs,
	output logic                       vga_vs,
	output logic                       vga_cs
);
	import rtg_pkg::*;

	logic [COLOR_W-1:0] hc_r_d, hc_g_d, hc_b_d;
	logic [COLOR_W-1:0] sel_r, sel_g, sel_b;
	logic               rtg_on;
	logic [1:0]         osd_rg;  // Overlay code for red and green
	logic [1:0]         osd_bl;  // Blue differs when the OSD pixel is off
	logic               sync_inv;

	// OSD code on top, colour shifted down beneath it
	function automatic logic [COLOR_W-1:0] osd_blend(input logic win, input logic [1:0] code,
		input logic [COLOR_W-1:0] c);
		return win ? {code, c[COLOR_W-1:2]} : c;
	endfunction

	////////////////////////////////////////////////////////////////////
	// Colour select
	////////////////////////////////////////////////////////////////////

	// Matches the palette read register
	always_ff @(posedge CLK_114) begin
		hc_r_d <= hc_r;
		hc_g_d <= hc_g;
		hc_b_d <= hc_b;
	end

	assign rtg_on = rtg_ena & ~blank_d2; // Native colour during RTG blank

	assign sel_r = rtg_on ? (rtg_clut_mode ? clut_r : hc_r_d) : nat_r;
	assign sel_g = rtg_on ? (rtg_clut_mode ? clut_g : hc_g_d) : nat_g;
	assign sel_b = rtg_on ? (rtg_clut_mode ? clut_b : hc_b_d) : nat_b;

	assign osd_rg = osd_pixel ? 2'b11 : 2'b00;
	assign osd_bl = osd_pixel ? 2'b11 : 2'b10; // Bluish OSD background

	// Native modes may need the syncs flipped for some monitors
	assign sync_inv = ~rtg_ena & invert_sync;

	////////////////////////////////////////////////////////////////////
	// Output registers
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (rst) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
			vga_cs <= 1'b0;
		end else begin
			vga_r  <= osd_blend(osd_window, osd_rg, sel_r);
			vga_g  <= osd_blend(osd_window, osd_rg, sel_g);
			vga_b  <= osd_blend(osd_window, osd_bl, sel_b);
			vga_hs <= hs ^ hsync_pol ^ sync_inv;
			vga_vs <= vs ^ vsync_pol ^ sync_inv;
			vga_cs <= cs;                   // Composite sync as is
		end
	end

endmodule

//--- hw/rtg_pixel_decode.sv
`timescale 1ns/1ps

module rtg_pixel_decode (
	input  rtg_pkg::pixel_word_t           rtg_dat,
	input  logic                           byte_sel,    // Already delayed one clock
	input  logic                           rtg_16bit,   // 565 when set, else 555
	output logic [rtg_pkg::COLOR_W-1:0]    hc_r,
	output logic [rtg_pkg::COLOR_W-1:0]    hc_g,
	output logic [rtg_pkg::COLOR_W-1:0]    hc_b,
	output logic [rtg_pkg::CLUT_IDX_W-1:0] clut_rd_idx
);
	import rtg_pkg::*;

	////////////////////////////////////////////////////////////////////
	// Field expansion
	////////////////////////////////////////////////////////////////////

	// Top bits repeated into the low end so full scale stays full scale
	function automatic logic [COLOR_W-1:0] expand5(input logic [4:0] f);
		return {f, f[4 -: COLOR_W-5]};
	endfunction

	function automatic logic [COLOR_W-1:0] expand6(input logic [5:0] f);
		return {f, f[5 -: COLOR_W-6]};
	endfunction

	////////////////////////////////////////////////////////////////////
	// High colour
	////////////////////////////////////////////////////////////////////

	always_comb begin
		if (rtg_16bit) begin
			hc_r = expand5(rtg_dat.hc16.r);
			hc_g = expand6(rtg_dat.hc16.g);  // Six bits of green
			hc_b = expand5(rtg_dat.hc16.b);
		end else begin
			hc_r = expand5(rtg_dat.hc15.r);  // Bit 15 ignored
			hc_g = expand5(rtg_dat.hc15.g);
			hc_b = expand5(rtg_dat.hc15.b);
		end
	end

	////////////////////////////////////////////////////////////////////
	// Palette index
	////////////////////////////////////////////////////////////////////

	// High byte is the left pixel of the pair
	assign clut_rd_idx = byte_sel ? rtg_dat.idx.lo : rtg_dat.idx.hi;

endmodule

//--- hw/rtg_clut.sv
`timescale 1ns/1ps

module rtg_clut (
	input  logic                          CLK_114,
	input  logic                          clut_we,     // Single cycle write strobe
	input  logic [rtg_pkg::CLUT_IDX_W-1:0] clut_wr_idx,
	input  logic [rtg_pkg::COLOR_W-1:0]    clut_wr_r,
	input  logic [rtg_pkg::COLOR_W-1:0]    clut_wr_g,
	input  logic [rtg_pkg::COLOR_W-1:0]    clut_wr_b,
	input  logic [rtg_pkg::CLUT_IDX_W-1:0] rd_idx,
	output logic [rtg_pkg::COLOR_W-1:0]    rd_r,        // Valid one clock after rd_idx
	output logic [rtg_pkg::COLOR_W-1:0]    rd_g,
	output logic [rtg_pkg::COLOR_W-1:0]    rd_b
);
	import rtg_pkg::*;

	localparam int ENTRY_W = 3 * COLOR_W; // R, G, B packed per entry

	////////////////////////////////////////////////////////////////////
	// Palette storage
	////////////////////////////////////////////////////////////////////

	logic [ENTRY_W-1:0] pal_mem [CLUT_DEPTH];
	logic [ENTRY_W-1:0] rd_entry;

	// Write port
	always_ff @(posedge CLK_114) begin
		if (clut_we)
			pal_mem[clut_wr_idx] <= {clut_wr_r, clut_wr_g, clut_wr_b};
	end

	// Registered read, maps onto block RAM
	always_ff @(posedge CLK_114) begin
		rd_entry <= pal_mem[rd_idx];
	end

	// Unpack the entry
	assign rd_r = rd_entry[3*COLOR_W-1:2*COLOR_W];
	assign rd_g = rd_entry[2*COLOR_W-1:COLOR_W];
	assign rd_b = rd_entry[COLOR_W-1:0];

	// Writes to the entry being read show up on the next read

endmodule

//--- hw/rtg_vblank_extend.sv
`timescale 1ns/1ps

module rtg_vblank_extend #(
	parameter int VBEND_W = 7
) (
	input  logic               CLK_114,
	input  logic               rst,
	input  logic               vblank,     // Chipset vertical blank
	input  logic               hs,
	input  logic [VBEND_W-1:0] vb_end,     // Extra lines to hold blank
	output logic               rtg_vblank
);

	logic [VBEND_W-1:0] line_ctr;
	logic               hs_d;
	logic               hs_rise;

	// Own copy of hsync for edge detection
	always_ff @(posedge CLK_114) begin
		if (rst)
			hs_d <= 1'b0;
		else
			hs_d <= hs;
	end

	assign hs_rise = hs & ~hs_d;

	////////////////////////////////////////////////////////////////////
	// Line counter after chipset vblank
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (rst) begin
			rtg_vblank <= 1'b1;
			line_ctr   <= '0;
		end else if (vblank) begin
			rtg_vblank <= 1'b1;          // Hold blank and restart count
			line_ctr   <= '0;
		end else if (line_ctr == vb_end) begin
			rtg_vblank <= 1'b0;          // Enough lines passed
		end else if (hs_rise) begin
			line_ctr <= line_ctr + 1'b1; // One more line
		end
	end

	// The counter stops at vb_end, so no wrap until the next vblank
	// Programming vb_end to zero drops blank right after vblank ends

endmodule

//--- hw/rtg_pixel_timing.sv
`timescale 1ns/1ps

module rtg_pixel_timing (
	input  logic                      CLK_114,
	input  logic                      rst,
	input  logic                      rtg_ena,
	input  logic                      rtg_clut_mode,
	input  logic                      scandbl_off,
	input  logic [rtg_pkg::PIXW_W-1:0] pixel_width, // Clocks per fetch minus one
	input  logic                      rtg_vblank,
	input  logic                      hblank,
	output logic                      pixel_req,   // Fetch strobe to the pixel source
	output logic                      byte_sel,    // Low = high byte of the word
	output logic                      blank_d2,
	output logic                      vga_pixel
);
	import rtg_pkg::*;

	localparam int NAT_CTR_W = 3; // Native strobe every 8 clocks

	logic                 blank;
	logic                 blank_d;
	logic [PIXW_W-1:0]    pixel_ctr;
	logic                 pixel_req_d;
	logic                 sel;        // Byte alternation, set mid fetch period
	logic                 clut_pixel;
	logic [NAT_CTR_W-1:0] nat_ctr;
	logic                 nat_strobe;

	assign blank = rtg_vblank | hblank;

	////////////////////////////////////////////////////////////////////
	// Fetch divider
	////////////////////////////////////////////////////////////////////

	assign pixel_req = rtg_ena & ~blank & (pixel_ctr == pixel_width);

	always_ff @(posedge CLK_114) begin
		if (rst) begin
			pixel_ctr   <= '0;
			pixel_req_d <= 1'b0;
			sel         <= 1'b0;
			byte_sel    <= 1'b0;
		end else begin
			pixel_req_d <= pixel_req;
			byte_sel    <= sel;                  // Delayed copy picks the byte
			if (pixel_ctr == (pixel_width >> 1))
				sel <= 1'b1;                     // Second index halfway through
			if (blank || pixel_req) begin
				pixel_ctr <= '0;
				sel       <= 1'b0;               // Back to the high byte
			end else begin
				pixel_ctr <= pixel_ctr + 1'b1;
			end
		end
	end

	// Rising edge of the alternation gives the second palette pixel
	assign clut_pixel = sel & ~byte_sel;

	////////////////////////////////////////////////////////////////////
	// Blank delay line
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (rst) begin
			blank_d  <= 1'b1; // Start out blanked
			blank_d2 <= 1'b1;
		end else begin
			blank_d  <= blank;
			blank_d2 <= blank_d;
		end
	end

	////////////////////////////////////////////////////////////////////
	// Native pixel strobe
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_114) begin
		if (rst)
			nat_ctr <= NAT_CTR_W'(1); // Keeps the strobe quiet out of reset
		else if (scandbl_off)
			nat_ctr <= {nat_ctr[NAT_CTR_W-1:1], 1'b0} + NAT_CTR_W'(2); // Step two, even only
		else
			nat_ctr <= nat_ctr + 1'b1;
	end

	assign nat_strobe = (nat_ctr == '0);

	// Exported strobe for the downstream dither stage
	assign vga_pixel = rtg_ena ? (pixel_req_d | (clut_pixel & rtg_clut_mode)) : nat_strobe;

endmodule

//--- hw/rtg_pkg.sv
package rtg_pkg;

	////////////////////////////////////////////////////////////////////
	// Widths shared across the RTG display path
	////////////////////////////////////////////////////////////////////

	parameter int COLOR_W    = 8;   // One output colour channel
	parameter int PIXW_W     = 4;   // Pixel clock divider setting
	parameter int CLUT_DEPTH = 256; // Palette entries
	parameter int CLUT_IDX_W = 8;   // Palette index

	////////////////////////////////////////////////////////////////////
	// One fetched pixel word, three ways of reading it
	////////////////////////////////////////////////////////////////////

	typedef union packed {
		struct packed {
			logic [4:0] r;
			logic [5:0] g;      // Green gets the spare bit in 565
			logic [4:0] b;
		} hc16;
		struct packed {
			logic       unused; // Top bit ignored in 555
			logic [4:0] r;
			logic [4:0] g;
			logic [4:0] b;
		} hc15;
		struct packed {
			logic [CLUT_IDX_W-1:0] hi; // First pixel on screen
			logic [CLUT_IDX_W-1:0] lo; // Second pixel
		} idx;
	} pixel_word_t;

endpackage
